//--- cpuDatapathPkg.sv
package cpuDatapathPkg;

    // datapath and zero-page address widths
    localparam int dataWidth = 8;
    localparam int addrWidth = 8;

    typedef logic [dataWidth-1:0] byteT;
    typedef logic [addrWidth-1:0] addrT;

    // one command per operation, no opcode decoding
    typedef enum logic [3:0] {
        opLda = 4'd0,
        opSta = 4'd1,
        opAdc = 4'd2,
        opAnd = 4'd3,
        opEor = 4'd4,
        opOra = 4'd5,
        opLsr = 4'd6,
        opTax = 4'd7,
        opTay = 4'd8,
        opTxa = 4'd9,
        opTya = 4'd10,
        opSec = 4'd11,
        opClc = 4'd12,
        opSed = 4'd13,
        opCld = 4'd14
    } opT;

    // status byte layout NV-BDIZC, only the kept flags
    localparam int flagC = 0;
    localparam int flagZ = 1;
    localparam int flagD = 3;
    localparam int flagV = 6;
    localparam int flagN = 7;

    // bit 5 always reads as one
    localparam byteT statusReset = 8'h20;

endpackage

//--- memPortIf.sv
`timescale 1ns/1ps

interface memPortIf import cpuDatapathPkg::*; ();

    // request side, held stable until done
    logic req;
    logic we;
    addrT addr;
    byteT wdata;

    // response side, done is a single-cycle pulse
    byteT rdata;
    logic done;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport responder (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

//--- aluCore.sv
`timescale 1ns/1ps

module aluCore import cpuDatapathPkg::*; (
    input  opT   op,
    input  byteT a,
    input  byteT b,
    input  logic carryIn,
    output byteT sum,
    output logic carryOut,
    output logic halfCarry,
    output logic overflow
);

    logic [4:0] loNibble;
    logic [4:0] hiNibble;

    // nibble-wise add so the half carry falls out of the low stage
    assign loNibble = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, carryIn};
    assign hiNibble = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'd0, loNibble[4]};

    always_comb begin
        sum       = b;
        carryOut  = 1'b0;
        halfCarry = 1'b0;
        overflow  = 1'b0;
        case (op)
            opAdc: begin
                sum       = {hiNibble[3:0], loNibble[3:0]};
                halfCarry = loNibble[4];
                carryOut  = hiNibble[4];
                // signed overflow when both operands agree in sign and the sum does not
                overflow  = (a[7] == b[7]) && (hiNibble[3] != a[7]);
            end
            opAnd: begin
                sum = a & b;
            end
            opEor: begin
                sum = a ^ b;
            end
            opOra: begin
                sum = a | b;
            end
            opLsr: begin
                // zero fill, bit 0 goes out through the carry
                sum      = {1'b0, a[7:1]};
                carryOut = a[0];
            end
            default: begin
                // loads and transfers route the b operand straight through
                sum = b;
            end
        endcase
    end

endmodule

//--- decimalAdjust.sv
`timescale 1ns/1ps

module decimalAdjust import cpuDatapathPkg::*; (
    input  logic decimalMode,
    input  opT   op,
    input  byteT binSum,
    input  logic binCarry,
    input  logic halfCarry,
    output byteT result,
    output logic carryOut
);

    byteT lowFixed;

    // low digit correction, wraps at 8 bits
    always_comb begin
        if (halfCarry || (binSum[3:0] > 4'd9)) begin
            lowFixed = binSum + 8'h06;
        end else begin
            lowFixed = binSum;
        end
    end

    always_comb begin
        result   = binSum;
        carryOut = binCarry;
        if (decimalMode && (op == opAdc)) begin
            // high digit correction also produces the decimal carry
            if (binCarry || (lowFixed > 8'h99)) begin
                result   = lowFixed + 8'h60;
                carryOut = 1'b1;
            end else begin
                result   = lowFixed;
                carryOut = binCarry;
            end
        end
    end

endmodule

//--- statusFlags.sv
`timescale 1ns/1ps

module statusFlags import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    input  logic update,
    input  opT   op,
    input  byteT result,
    input  logic carry,
    input  logic overflow,
    output byteT status
);

    logic resultZero;
    logic resultNeg;

    assign resultZero = (result == '0);
    assign resultNeg  = result[7];

    // bits 5 and 4 are never written after reset
    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            status <= statusReset;
        end else if (update) begin
            case (op)
                opAdc: begin
                    status[flagN] <= resultNeg;
                    status[flagZ] <= resultZero;
                    status[flagC] <= carry;
                    status[flagV] <= overflow;
                end
                opAnd, opEor, opOra, opLda, opTax, opTay, opTxa, opTya: begin
                    status[flagN] <= resultNeg;
                    status[flagZ] <= resultZero;
                end
                opLsr: begin
                    // shifted-in zero leaves N clear
                    status[flagN] <= 1'b0;
                    status[flagZ] <= resultZero;
                    status[flagC] <= carry;
                end
                opSec: begin
                    status[flagC] <= 1'b1;
                end
                opClc: begin
                    status[flagC] <= 1'b0;
                end
                opSed: begin
                    status[flagD] <= 1'b1;
                end
                opCld: begin
                    status[flagD] <= 1'b0;
                end
                default: begin
                    // store leaves every flag alone
                    status <= status;
                end
            endcase
        end
    end

endmodule

//--- registerBank.sv
`timescale 1ns/1ps

module registerBank import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    input  logic update,
    input  opT   op,
    input  byteT result,
    output byteT regA,
    output byteT regX,
    output byteT regY
);

    logic writeA;
    logic writeX;
    logic writeY;

    // destination select, flag ops and stores write nothing
    always_comb begin
        writeA = 1'b0;
        writeX = 1'b0;
        writeY = 1'b0;
        case (op)
            opTax: writeX = update;
            opTay: writeY = update;
            opLda, opAdc, opAnd, opEor, opOra, opLsr, opTxa, opTya: writeA = update;
            default: writeA = 1'b0;
        endcase
    end

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            regA <= '0;
            regX <= '0;
            regY <= '0;
        end else begin
            if (writeA) regA <= result;
            if (writeX) regX <= result;
            if (writeY) regY <= result;
        end
    end

endmodule

//--- wbMaster.sv
`timescale 1ns/1ps

module wbMaster import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    memPortIf.responder mem,
    input  byteT wbDatI,
    input  logic wbAck,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output addrT wbAdr,
    output byteT wbDatO
);

    typedef enum logic {stIdle, stActive} stateT;

    stateT state;

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            wbWe  <= 1'b0;
        end else if (state == stIdle) begin
            if (mem.req) begin
                state <= stActive;
                wbWe  <= mem.we;
            end
        end else if (wbAck) begin
            // single classic transfer, strobes drop after the ack
            state <= stIdle;
            wbWe  <= 1'b0;
        end
    end

    // address and write data captured when the cycle opens
    always_ff @(posedge rstAll) begin
        if ((state == stIdle) && mem.req) begin
            wbAdr  <= mem.addr;
            wbDatO <= mem.wdata;
        end
    end

    assign wbCyc = (state == stActive);
    assign wbStb = (state == stActive);

    // read data is consumed at the ack edge itself
    assign mem.done  = (state == stActive) && wbAck;
    assign mem.rdata = wbDatI;

endmodule

//--- opSequencer.sv
`timescale 1ns/1ps

module opSequencer import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    input  logic cmdValid,
    input  opT   cmdOp,
    input  logic cmdMem,
    input  addrT cmdAddr,
    input  byteT cmdImm,
    input  byteT regA,
    input  byteT regX,
    input  byteT regY,
    output logic cmdReady,
    memPortIf.requester mem,
    output opT   aluOp,
    output byteT aluA,
    output byteT aluB,
    output logic update
);

    logic busy;
    logic accept;
    opT   pendOp;
    addrT pendAddr;
    opT   curOp;
    byteT operand;

    // stores always go to memory, a few ops may take a memory operand
    function automatic logic needsMem(opT op, logic useMem);
        case (op)
            opSta: return 1'b1;
            opLda, opAdc, opAnd, opEor, opOra: return useMem;
            default: return 1'b0;
        endcase
    endfunction

    assign cmdReady = ~busy;
    assign accept   = cmdValid && cmdReady;

    always_ff @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
        end else if (accept && needsMem(cmdOp, cmdMem)) begin
            busy <= 1'b1;
        end else if (mem.done) begin
            busy <= 1'b0;
        end
    end

    // pending command kept while the bus transfer runs
    always_ff @(posedge rstAll) begin
        if (accept && needsMem(cmdOp, cmdMem)) begin
            pendOp   <= cmdOp;
            pendAddr <= cmdAddr;
        end
    end

    // regA cannot change while busy, so the store data stays stable
    assign mem.req   = busy;
    assign mem.we    = (pendOp == opSta);
    assign mem.addr  = pendAddr;
    assign mem.wdata = regA;

    // operand is either the immediate or the returned read data
    always_comb begin
        curOp   = busy ? pendOp : cmdOp;
        operand = busy ? mem.rdata : cmdImm;
        aluOp   = curOp;
        aluA    = regA;
        case (curOp)
            opTxa: aluB = regX;
            opTya: aluB = regY;
            opTax, opTay: aluB = regA;
            default: aluB = operand;
        endcase
    end

    // execute at acceptance for register ops, at done for memory ops
    assign update = (accept && !needsMem(cmdOp, cmdMem)) || mem.done;

endmodule

//--- cpuDatapath.sv
`timescale 1ns/1ps

module cpuDatapath import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    input  logic cmdValid,
    output logic cmdReady,
    input  opT   cmdOp,
    input  logic cmdMem,
    input  addrT cmdAddr,
    input  byteT cmdImm,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output addrT wbAdr,
    output byteT wbDatO,
    input  byteT wbDatI,
    input  logic wbAck,
    output byteT regA,
    output byteT regX,
    output byteT regY,
    output byteT status
);

    memPortIf memBus ();

    opT   aluOp;
    byteT aluA;
    byteT aluB;
    logic update;
    byteT binSum;
    logic binCarry;
    logic halfCarry;
    logic overflow;
    byteT result;
    logic carry;
    logic carryIn;
    logic decimalMode;

    // ALU carry-in and BCD mode come straight from the status register
    assign carryIn     = status[flagC];
    assign decimalMode = status[flagD];

    opSequencer seq0 (
        .rstAll  (rstAll),
        .arstN   (arstN),
        .cmdValid(cmdValid),
        .cmdOp   (cmdOp),
        .cmdMem  (cmdMem),
        .cmdAddr (cmdAddr),
        .cmdImm  (cmdImm),
        .regA    (regA),
        .regX    (regX),
        .regY    (regY),
        .cmdReady(cmdReady),
        .mem     (memBus.requester),
        .aluOp   (aluOp),
        .aluA    (aluA),
        .aluB    (aluB),
        .update  (update)
    );

    wbMaster wb0 (
        .rstAll(rstAll),
        .arstN (arstN),
        .mem   (memBus.responder),
        .wbDatI(wbDatI),
        .wbAck (wbAck),
        .wbCyc (wbCyc),
        .wbStb (wbStb),
        .wbWe  (wbWe),
        .wbAdr (wbAdr),
        .wbDatO(wbDatO)
    );

    aluCore alu0 (
        .op       (aluOp),
        .a        (aluA),
        .b        (aluB),
        .carryIn  (carryIn),
        .sum      (binSum),
        .carryOut (binCarry),
        .halfCarry(halfCarry),
        .overflow (overflow)
    );

    decimalAdjust dec0 (
        .decimalMode(decimalMode),
        .op         (aluOp),
        .binSum     (binSum),
        .binCarry   (binCarry),
        .halfCarry  (halfCarry),
        .result     (result),
        .carryOut   (carry)
    );

    statusFlags flags0 (
        .rstAll  (rstAll),
        .arstN   (arstN),
        .update  (update),
        .op      (aluOp),
        .result  (result),
        .carry   (carry),
        .overflow(overflow),
        .status  (status)
    );

    registerBank regs0 (
        .rstAll(rstAll),
        .arstN (arstN),
        .update(update),
        .op    (aluOp),
        .result(result),
        .regA  (regA),
        .regX  (regX),
        .regY  (regY)
    );

endmodule

//--- cpuDatapathChecker.sv
`timescale 1ns/1ps

module cpuDatapathChecker import cpuDatapathPkg::*; (
    input  logic rstAll,
    input  logic arstN,
    input  logic cmdValid,
    input  logic cmdReady,
    input  opT   cmdOp,
    input  logic cmdMem,
    input  addrT cmdAddr,
    input  byteT cmdImm,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  addrT wbAdr,
    input  byteT wbDatO,
    input  byteT wbDatI,
    input  logic wbAck,
    input  byteT regA,
    input  byteT regX,
    input  byteT regY,
    input  byteT status,
    output int   errorCount
);

    // reference model of the programmer-visible state
    byteT modelA;
    byteT modelX;
    byteT modelY;
    byteT modelP;
    // memory copy that is known only where a write was acknowledged
    byteT mirror [256];
    logic mirrorValid [256];
    logic pendValid;
    opT   pendOp;
    addrT pendAddr;
    logic resetChecked;

    initial begin
        errorCount = 0;
    end

    function automatic logic usesBus(opT op, logic useMem);
        if (op == opSta) begin
            return 1'b1;
        end
        return useMem && (op inside {opLda, opAdc, opAnd, opEor, opOra});
    endfunction

    task automatic checkByte(input string name, input byteT got, input byteT want);
        if (got !== want) begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("error at %0t: %s", $time, what);
        errorCount++;
    endtask

    task automatic setNz(input byteT value);
        modelP[flagN] = value[7];
        modelP[flagZ] = (value == 8'h00);
    endtask

    task automatic resetModel();
        int i;
        modelA = 8'h00;
        modelX = 8'h00;
        modelY = 8'h00;
        modelP = statusReset;
        pendValid = 1'b0;
        resetChecked = 1'b0;
        for (i = 0; i < 256; i++) begin
            mirrorValid[i] = 1'b0;
        end
    endtask

    task automatic applyOp(input opT op, input byteT operand);
        int binSum;
        int lowSum;
        byteT res;
        logic carry;
        case (op)
            opLda: begin
                modelA = operand;
                setNz(operand);
            end
            opAdc: begin
                binSum = modelA + operand + modelP[flagC];
                lowSum = modelA[3:0] + operand[3:0] + modelP[flagC];
                res = byteT'(binSum);
                carry = (binSum > 255);
                // V always follows the binary sum
                modelP[flagV] = (modelA[7] == operand[7]) && (res[7] != modelA[7]);
                if (modelP[flagD]) begin
                    if ((lowSum > 15) || (res[3:0] > 4'd9)) begin
                        res = res + 8'h06;
                    end
                    if (carry || (res > 8'h99)) begin
                        res = res + 8'h60;
                        carry = 1'b1;
                    end
                end
                modelA = res;
                modelP[flagC] = carry;
                setNz(res);
            end
            opAnd: begin
                modelA = modelA & operand;
                setNz(modelA);
            end
            opEor: begin
                modelA = modelA ^ operand;
                setNz(modelA);
            end
            opOra: begin
                modelA = modelA | operand;
                setNz(modelA);
            end
            opLsr: begin
                modelP[flagC] = modelA[0];
                modelA = modelA >> 1;
                setNz(modelA);
            end
            opTax: begin
                modelX = modelA;
                setNz(modelA);
            end
            opTay: begin
                modelY = modelA;
                setNz(modelA);
            end
            opTxa: begin
                modelA = modelX;
                setNz(modelX);
            end
            opTya: begin
                modelA = modelY;
                setNz(modelY);
            end
            opSec: modelP[flagC] = 1'b1;
            opClc: modelP[flagC] = 1'b0;
            opSed: modelP[flagD] = 1'b1;
            opCld: modelP[flagD] = 1'b0;
            default: begin
                // a store changes no register
                modelP = modelP;
            end
        endcase
    endtask

    task automatic handleAck();
        if (!pendValid) begin
            reportProblem("Wishbone ack while no memory command was pending");
        end else begin
            checkByte("wbAdr", wbAdr, pendAddr);
            checkByte("wbWe", byteT'(wbWe), byteT'(pendOp == opSta));
            if (pendOp == opSta) begin
                checkByte("wbDatO", wbDatO, modelA);
                mirror[pendAddr] = modelA;
                mirrorValid[pendAddr] = 1'b1;
            end else begin
                if (mirrorValid[pendAddr]) begin
                    checkByte("wbDatI", wbDatI, mirror[pendAddr]);
                end
                applyOp(pendOp, wbDatI);
            end
            pendValid = 1'b0;
        end
    endtask

    // compare the values held before this edge and then apply what the edge does
    always @(posedge rstAll or negedge arstN) begin
        if (!arstN) begin
            resetModel();
        end else begin
            if (!resetChecked) begin
                checkByte("wbStb", byteT'(wbStb), 8'h00);
                checkByte("wbWe", byteT'(wbWe), 8'h00);
                resetChecked = 1'b1;
            end
            // ready and the bus cycle follow the pending memory command
            checkByte("cmdReady", byteT'(cmdReady), byteT'(!pendValid));
            if (!pendValid) begin
                checkByte("wbCyc", byteT'(wbCyc), 8'h00);
            end
            if (cmdReady) begin
                checkByte("regA", regA, modelA);
                checkByte("regX", regX, modelX);
                checkByte("regY", regY, modelY);
                checkByte("status", status, modelP);
            end
            if (wbCyc !== wbStb) begin
                reportProblem("wbCyc and wbStb differ");
            end
            if (wbCyc && wbStb && wbAck) begin
                handleAck();
            end
            if (cmdValid && cmdReady) begin
                if (usesBus(cmdOp, cmdMem)) begin
                    pendValid = 1'b1;
                    pendOp = cmdOp;
                    pendAddr = cmdAddr;
                end else begin
                    applyOp(cmdOp, cmdImm);
                end
            end
        end
    end

endmodule

//--- cpuDatapathTb.sv
`timescale 1ns/1ps

module cpuDatapathTb import cpuDatapathPkg::*; ();

    logic rstAll;
    logic arstN;
    logic cmdValid;
    logic cmdReady;
    opT   cmdOp;
    logic cmdMem;
    addrT cmdAddr;
    byteT cmdImm;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    addrT wbAdr;
    byteT wbDatO;
    byteT wbDatI;
    logic wbAck;
    byteT regA;
    byteT regX;
    byteT regY;
    byteT status;

    int   errorCount;
    int   hangCount;
    int   seed = 32'h52c6;
    // wait states draw from their own stream so stimulus never shifts them
    int   waitSeed = 32'h52c6;
    int   waitLeft;
    byteT memory [256];

    cpuDatapath dut0 (
        .rstAll  (rstAll),
        .arstN   (arstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdOp   (cmdOp),
        .cmdMem  (cmdMem),
        .cmdAddr (cmdAddr),
        .cmdImm  (cmdImm),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatO  (wbDatO),
        .wbDatI  (wbDatI),
        .wbAck   (wbAck),
        .regA    (regA),
        .regX    (regX),
        .regY    (regY),
        .status  (status)
    );

    cpuDatapathChecker check0 (
        .rstAll    (rstAll),
        .arstN     (arstN),
        .cmdValid  (cmdValid),
        .cmdReady  (cmdReady),
        .cmdOp     (cmdOp),
        .cmdMem    (cmdMem),
        .cmdAddr   (cmdAddr),
        .cmdImm    (cmdImm),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatO    (wbDatO),
        .wbDatI    (wbDatI),
        .wbAck     (wbAck),
        .regA      (regA),
        .regX      (regX),
        .regY      (regY),
        .status    (status),
        .errorCount(errorCount)
    );

    initial begin
        rstAll = 1'b0;
        forever #5 rstAll = ~rstAll;
    end

    // Wishbone slave with 0 to 3 wait states, acks are driven on the falling edge
    always @(negedge rstAll or negedge arstN) begin
        if (!arstN) begin
            wbAck = 1'b0;
            waitLeft = 0;
        end else if (wbAck) begin
            wbAck = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft == 0) begin
                if (wbWe) begin
                    memory[wbAdr] = wbDatO;
                end else begin
                    wbDatI = memory[wbAdr];
                end
                wbAck = 1'b1;
            end else begin
                waitLeft--;
            end
        end else begin
            waitLeft = $unsigned($random(waitSeed)) % 4;
        end
    end

    function automatic byteT randByte();
        return byteT'($random(seed));
    endfunction

    function automatic byteT randBcd();
        int tens;
        int ones;
        tens = $unsigned($random(seed)) % 10;
        ones = $unsigned($random(seed)) % 10;
        return byteT'(tens * 16 + ones);
    endfunction

    task automatic finishRun();
        $display("closing report: %0d check errors, %0d timeouts", errorCount, hangCount);
        if ((errorCount == 0) && (hangCount == 0)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // called on a falling edge, returns on a falling edge with cmdReady high
    task automatic waitReady();
        int waited;
        waited = 0;
        while ((cmdReady !== 1'b1) && (waited < 50)) begin
            cmdValid = 1'b0;
            @(negedge rstAll);
            waited++;
        end
        if (cmdReady !== 1'b1) begin
            $display("timeout: cmdReady stayed low for 50 cycles, no Wishbone ack came back");
            hangCount++;
            finishRun();
        end
    endtask

    task automatic issueCmd(input opT op, input logic useMem, input addrT addr, input byteT imm);
        waitReady();
        cmdValid = 1'b1;
        cmdOp = op;
        cmdMem = useMem;
        cmdAddr = addr;
        cmdImm = imm;
        @(negedge rstAll);
    endtask

    task automatic idleCycle();
        cmdValid = 1'b0;
        cmdImm = randByte();
        @(negedge rstAll);
    endtask

    // immediate and memory ALU ops, loads, stores, transfers and SEC/CLC
    task automatic binaryPhase(input int count);
        int n;
        opT op;
        logic useMem;
        for (n = 0; n < count; n++) begin
            op = opT'($unsigned($random(seed)) % 13);
            useMem = (($random(seed) & 3) == 0);
            if (($random(seed) & 7) == 0) begin
                idleCycle();
            end
            issueCmd(op, useMem, addrT'($random(seed) & 32'h1f), randByte());
        end
    endtask

    // store then reload over the whole address range
    task automatic memoryPhase(input int count);
        int n;
        byteT value;
        addrT addr;
        for (n = 0; n < count; n++) begin
            value = randByte();
            addr = randByte();
            issueCmd(opLda, 1'b0, 8'h00, value);
            issueCmd(opSta, 1'b0, addr, randByte());
            issueCmd(opLda, 1'b0, 8'h00, ~value);
            issueCmd(opLda, 1'b1, addr, randByte());
            issueCmd(opAdc, 1'b1, addr + 8'h01, randByte());
        end
    endtask

    task automatic decimalPhase(input int count);
        int n;
        issueCmd(opSed, 1'b0, 8'h00, 8'h00);
        for (n = 0; n < count; n++) begin
            issueCmd(opLda, 1'b0, 8'h00, randBcd());
            if ($random(seed) & 1) begin
                issueCmd(opSec, 1'b0, 8'h00, 8'h00);
            end else begin
                issueCmd(opClc, 1'b0, 8'h00, 8'h00);
            end
            issueCmd(opAdc, 1'b0, 8'h00, randBcd());
        end
        // back to binary sums
        issueCmd(opCld, 1'b0, 8'h00, 8'h00);
        for (n = 0; n < 20; n++) begin
            issueCmd(opAdc, 1'b0, 8'h00, randByte());
        end
    endtask

    initial begin
        int i;
        hangCount = 0;
        arstN = 1'b0;
        cmdValid = 1'b0;
        cmdOp = opLda;
        cmdMem = 1'b0;
        cmdAddr = 8'h00;
        cmdImm = 8'h00;
        wbDatI = 8'h00;
        wbAck = 1'b0;
        for (i = 0; i < 256; i++) begin
            memory[i] = byteT'($random(seed));
        end
        repeat (2) @(posedge rstAll);
        @(negedge rstAll);
        arstN = 1'b1;
        @(negedge rstAll);
        binaryPhase(400);
        memoryPhase(40);
        decimalPhase(100);
        binaryPhase(100);
        // let the last command retire and be compared
        waitReady();
        cmdValid = 1'b0;
        repeat (2) @(negedge rstAll);
        finishRun();
    end

endmodule

//--- cpuDatapath.f
cpuDatapathPkg.sv
memPortIf.sv
aluCore.sv
decimalAdjust.sv
statusFlags.sv
registerBank.sv
wbMaster.sv
opSequencer.sv
cpuDatapath.sv
cpuDatapathChecker.sv
cpuDatapathTb.sv

//--- Bender.yml
package:
  name: cpu_datapath

sources:
  - cpuDatapathPkg.sv
  - memPortIf.sv
  - aluCore.sv
  - decimalAdjust.sv
  - statusFlags.sv
  - registerBank.sv
  - wbMaster.sv
  - opSequencer.sv
  - cpuDatapath.sv
  - target: test
    files:
      - cpuDatapathChecker.sv
      - cpuDatapathTb.sv
